/* test/coreStimulus.txt */
// test instr valid expected_result expected_illegal
// test and valid are decimal, instr and expected_result are hex.
1 00000000 0 00000000 0
1 13120000 1 00000000 0
2 91001234 1 12340000 0
2 81105678 1 12345678 0
2 9200FFFF 1 FFFF0000 0
2 82208001 1 FFFE8001 0
2 8400FFFF 1 FFFFFFFF 0
2 85000024 1 00000024 0
3 16120000 1 1232D679 0
3 17440000 1 FFFFFFFE 0
3 28510000 1 EDCBA9AC 0
3 39120000 1 12340000 0
3 4A120000 1 FFFED679 0
3 5B140000 1 EDCBA987 0
3 6C150000 1 23456780 0
3 7D250000 1 0FFFE800 0
4 80007FFF 1 00007FFF 0
4 1E000000 1 00000000 0
4 1E100000 1 12345678 0
4 1F020000 1 FFFE8001 0
4 23660000 1 00000000 0
4 00000000 0 00000000 0
5 83500001 1 00000025 0
5 13330000 1 0000004A 0
5 63350000 1 000004A0 0
5 23340000 1 000004A1 0
5 53310000 1 123452D9 0
6 01230000 1 00000000 0
6 A1120000 1 00000000 1
6 C3000000 1 00000000 1
6 F2120000 1 00000000 1
6 16100000 1 12345678 0
6 17200000 1 FFFE8001 0
6 17300000 1 123452D9 0

/* verilog.f */
logic/corePkg.sv
logic/regPortIf.sv
logic/registerFile.sv
logic/instrDecoder.sv
logic/alu.sv
logic/execCore.sv
test/execCoreTb.sv

/* Bender.yml */
package:
  name: exec_core

sources:
  - files:
      - logic/corePkg.sv
      - logic/regPortIf.sv
      - logic/registerFile.sv
      - logic/instrDecoder.sv
      - logic/alu.sv
      - logic/execCore.sv
  - target: test
    files:
      - test/execCoreTb.sv

/* test/execCoreTb.sv */
`timescale 1ns/1ns
`default_nettype none

module execCoreTb;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_INSTRS = 6;
    localparam int MARGIN_CYCLES = 100;

    logic          iClk;
    logic          reset;
    corePkg::dataT instr;
    logic          valid;
    corePkg::dataT result;
    logic          resultValid;
    logic          illegal;

    // Stimulus lines from the data file.
    int          testNumQ [$];
    logic [31:0] instrQ [$];
    logic        validQ [$];
    logic [31:0] expResultQ [$];
    logic        expIllegalQ [$];

    // Expectation for the instruction driven in the previous cycle.
    bit          havePending;
    logic        pendValid;
    logic [31:0] pendResult;
    logic        pendIllegal;

    integer seed;
    bit     started;
    int     currentTest;
    int     testErrors;
    int     errorCount;
    int     passCount;
    int     failCount;

    execCore DUT (
        .iClk        (iClk),
        .reset       (reset),
        .instr       (instr),
        .valid       (valid),
        .result      (result),
        .resultValid (resultValid),
        .illegal     (illegal)
    );

    always #(CLK_PERIOD / 2) iClk = ~iClk;

    task automatic loadStimulus(output bit ok);
        int          fd;
        int          n;
        string       line;
        int          tNum;
        logic [31:0] tInstr;
        int          tValid;
        logic [31:0] tResult;
        int          tIllegal;
        fd = $fopen("test/coreStimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Comment and blank lines are skipped.
                if (n > 0 && line.len() > 1 && line[0] != "/") begin
                    n = $sscanf(line, "%d %h %d %h %d",
                                tNum, tInstr, tValid, tResult, tIllegal);
                    if (n == 5) begin
                        testNumQ.push_back(tNum);
                        instrQ.push_back(tInstr);
                        validQ.push_back(tValid != 0);
                        expResultQ.push_back(tResult);
                        expIllegalQ.push_back(tIllegal != 0);
                    end
                end
            end
            $fclose(fd);
        end
        ok = (fd != 0) && (testNumQ.size() > 0);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got %h, expected %h (test %0d)",
                     name, actual, expected, currentTest);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkPending();
        if (havePending) begin
            if (pendValid) begin
                checkValue("resultValid", {31'b0, resultValid}, 32'h1);
                checkValue("result", result, pendResult);
                checkValue("illegal", {31'b0, illegal}, {31'b0, pendIllegal});
            end else begin
                checkValue("resultValid", {31'b0, resultValid}, 32'h0);
            end
        end
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            passCount++;
            $display("Test %0d: pass", currentTest);
        end else begin
            failCount++;
            $display("Test %0d: FAIL with %0d mismatches", currentTest, testErrors);
        end
        testErrors = 0;
    endtask

    // Checks the previous instruction's output and drives the next one in the same cycle.
    task automatic issueInstr(input int testNum, input logic [31:0] word, input logic v,
                              input logic [31:0] expResult, input logic expIllegal);
        @(posedge iClk);
        #1;
        checkPending();
        if (testNum != currentTest) begin
            finishTest();
            currentTest = testNum;
        end
        instr       = word;
        valid       = v;
        havePending = 1'b1;
        pendValid   = v;
        pendResult  = expResult;
        pendIllegal = expIllegal;
    endtask

    // Random constants built with LUI and ADDI and then summed and subtracted.
    task automatic runRandomTest(input int testNum);
        logic [31:0] rnd;
        logic [31:0] value [2];
        logic [3:0]  regNum;
        for (int k = 0; k < 2; k++) begin
            rnd    = $random(seed);
            regNum = 4'h8 + 4'(k);
            value[k] = {rnd[31:16], 16'h0000};
            issueInstr(testNum, {corePkg::OP_LUI, regNum, 4'h0, 4'h0, rnd[31:16]},
                       1'b1, value[k], 1'b0);
            value[k] = value[k] + {{16{rnd[15]}}, rnd[15:0]};
            issueInstr(testNum, {corePkg::OP_ADDI, regNum, regNum, 4'h0, rnd[15:0]},
                       1'b1, value[k], 1'b0);
        end
        issueInstr(testNum, {corePkg::OP_ADD, 4'hA, 4'h8, 4'h9, 16'h0000},
                   1'b1, value[0] + value[1], 1'b0);
        issueInstr(testNum, {corePkg::OP_SUB, 4'hB, 4'h8, 4'h9, 16'h0000},
                   1'b1, value[0] - value[1], 1'b0);
    endtask

    initial begin
        bit ok;
        iClk        = 1'b0;
        reset       = 1'b1;
        // A writing instruction held during reset must leave no trace.
        valid       = 1'b1;
        instr       = {corePkg::OP_LUI, 4'h1, 8'h00, 16'hFFFF};
        seed        = 32'h96be1a02;
        started     = 1'b0;
        havePending = 1'b0;
        testErrors  = 0;
        errorCount  = 0;
        passCount   = 0;
        failCount   = 0;
        loadStimulus(ok);
        if (!ok) begin
            $display("The stimulus file test/coreStimulus.txt is missing or empty");
            $display("test failed");
            $finish;
        end else begin
            started = 1'b1;
            repeat (RESET_CYCLES) @(posedge iClk);
            #1;
            reset       = 1'b0;
            valid       = 1'b0;
            instr       = '0;
            currentTest = testNumQ[0];
            checkValue("resultValid", {31'b0, resultValid}, 32'h0);
            checkValue("illegal", {31'b0, illegal}, 32'h0);
            checkValue("result", result, 32'h0);
            for (int i = 0; i < testNumQ.size(); i++) begin
                issueInstr(testNumQ[i], instrQ[i], validQ[i], expResultQ[i], expIllegalQ[i]);
            end
            runRandomTest(testNumQ[testNumQ.size() - 1] + 1);
            // Trailing bubble so the last instruction and the idle cycle get checked.
            issueInstr(currentTest, 32'h0, 1'b0, 32'h0, 1'b0);
            @(posedge iClk);
            #1;
            checkPending();
            finishTest();
            $display("Summary: %0d tests pass, %0d tests fail, %0d mismatches",
                     passCount, failCount, errorCount);
            if (errorCount == 0 && failCount == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

    initial begin
        wait (started);
        #((testNumQ.size() + RANDOM_INSTRS + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Simulation timed out before all instructions were checked");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/execCore.sv */
`timescale 1ns/1ns
`default_nettype none

module execCore (
    input  logic          iClk,
    input  logic          reset,
    input  corePkg::dataT instr,
    input  logic          valid,
    output corePkg::dataT result,
    output logic          resultValid,
    output logic          illegal
);

    regPortIf regPorts ();

    corePkg::aluOpT aluOp;
    corePkg::dataT  imm;
    corePkg::dataT  aluB;
    corePkg::dataT  aluY;
    logic           useImm;
    logic           decIllegal;

    instrDecoder decoder (
        .instr   (instr),
        .valid   (valid),
        .addrA   (regPorts.addrA),
        .addrB   (regPorts.addrB),
        .addrC   (regPorts.addrC),
        .aluOp   (aluOp),
        .useImm  (useImm),
        .imm     (imm),
        .write   (regPorts.write),
        .illegal (decIllegal)
    );

    registerFile regFile (
        .iClk  (iClk),
        .reset (reset),
        .ports (regPorts.regFile)
    );

    assign aluB = useImm ? imm : regPorts.regB;

    alu alu0 (
        .a     (regPorts.regA),
        .b     (aluB),
        .aluOp (aluOp),
        .y     (aluY)
    );

    // Write-back happens at the same edge that latches the result.
    assign regPorts.regC = aluY;

    always_ff @(posedge iClk) begin
        if (reset) begin
            result      <= '0;
            resultValid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            // Non-writing instructions report zero.
            result      <= regPorts.write ? aluY : '0;
            resultValid <= valid;
            illegal     <= decIllegal;
        end
    end

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  corePkg::dataT  a,
    input  corePkg::dataT  b,
    input  corePkg::aluOpT aluOp,
    output corePkg::dataT  y
);

    // Shifts use the low five bits of b only.
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluOp)
            corePkg::ALU_ADD: begin
                y = a + b;
            end
            corePkg::ALU_SUB: begin
                y = a - b;
            end
            corePkg::ALU_AND: begin
                y = a & b;
            end
            corePkg::ALU_OR: begin
                y = a | b;
            end
            corePkg::ALU_XOR: begin
                y = a ^ b;
            end
            corePkg::ALU_SLL: begin
                y = a << shamt;
            end
            corePkg::ALU_SRL: begin
                y = a >> shamt;
            end
            corePkg::ALU_LUI: begin
                // Upper immediate arrives already shifted.
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/instrDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  corePkg::dataT    instr,
    input  logic             valid,
    output corePkg::regAddrT addrA,
    output corePkg::regAddrT addrB,
    output corePkg::regAddrT addrC,
    output corePkg::aluOpT   aluOp,
    output logic             useImm,
    output corePkg::dataT    imm,
    output logic             write,
    output logic             illegal
);

    corePkg::opcodeT opcode;
    logic [15:0]     imm16;
    logic            badOpcode;

    assign opcode = instr[corePkg::OPCODE_MSB:corePkg::OPCODE_LSB];
    assign addrC  = instr[corePkg::RC_MSB:corePkg::RC_LSB];
    assign addrA  = instr[corePkg::RA_MSB:corePkg::RA_LSB];
    assign addrB  = instr[corePkg::RB_MSB:corePkg::RB_LSB];
    assign imm16  = instr[corePkg::IMM_MSB:corePkg::IMM_LSB];

    // Everything above LUI is unassigned.
    assign badOpcode = opcode > corePkg::OP_LUI;

    always_comb begin
        aluOp  = corePkg::ALU_ADD;
        useImm = 1'b0;
        imm    = '0;
        case (opcode)
            corePkg::OP_SUB: aluOp = corePkg::ALU_SUB;
            corePkg::OP_AND: aluOp = corePkg::ALU_AND;
            corePkg::OP_OR:  aluOp = corePkg::ALU_OR;
            corePkg::OP_XOR: aluOp = corePkg::ALU_XOR;
            corePkg::OP_SLL: aluOp = corePkg::ALU_SLL;
            corePkg::OP_SRL: aluOp = corePkg::ALU_SRL;
            corePkg::OP_ADDI: begin
                useImm = 1'b1;
                imm    = {{16{imm16[15]}}, imm16};
            end
            corePkg::OP_LUI: begin
                aluOp  = corePkg::ALU_LUI;
                useImm = 1'b1;
                imm    = {imm16, 16'h0000};
            end
            default: aluOp = corePkg::ALU_ADD;
        endcase
    end

    // NOP and illegal opcodes never reach the register file.
    assign write   = valid && !badOpcode && (opcode != corePkg::OP_NOP);
    assign illegal = valid && badOpcode;

endmodule

`default_nettype wire

/* logic/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  logic iClk,
    input  logic reset,
    regPortIf.regFile ports
);

    // Register 0 has no storage and reads as zero.
    corePkg::dataT regs [1:15];

    logic writeEn;

    assign writeEn = ports.write && (ports.addrC != '0);

    always_ff @(posedge iClk) begin
        if (reset) begin
            for (int i = 1; i <= 15; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[ports.addrC] <= ports.regC;
        end
    end

    // Both read ports are combinational.
    always_comb begin
        if (ports.addrA == '0) begin
            ports.regA = '0;
        end else begin
            ports.regA = regs[ports.addrA];
        end
    end

    always_comb begin
        if (ports.addrB == '0) begin
            ports.regB = '0;
        end else begin
            ports.regB = regs[ports.addrB];
        end
    end

endmodule

`default_nettype wire

/* logic/regPortIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface regPortIf;

    // Read ports A and B.
    corePkg::regAddrT addrA;
    corePkg::regAddrT addrB;
    corePkg::dataT    regA;
    corePkg::dataT    regB;

    // Write port C.
    corePkg::regAddrT addrC;
    corePkg::dataT    regC;
    logic             write;

    modport core (
        output addrA, addrB, addrC,
        output write, regC,
        input  regA, regB
    );

    modport regFile (
        input  addrA, addrB, addrC,
        input  write, regC,
        output regA, regB
    );

endinterface

`default_nettype wire

/* logic/corePkg.sv */
`default_nettype none

package corePkg;

    typedef logic [31:0] dataT;
    typedef logic [3:0]  regAddrT;
    typedef logic [3:0]  opcodeT;
    typedef logic [2:0]  aluOpT;

    // ALU operations.
    localparam aluOpT ALU_ADD = 3'd0;
    localparam aluOpT ALU_SUB = 3'd1;
    localparam aluOpT ALU_AND = 3'd2;
    localparam aluOpT ALU_OR  = 3'd3;
    localparam aluOpT ALU_XOR = 3'd4;
    localparam aluOpT ALU_SLL = 3'd5;
    localparam aluOpT ALU_SRL = 3'd6;
    localparam aluOpT ALU_LUI = 3'd7;

    // Opcodes 10 to 15 are illegal.
    localparam opcodeT OP_NOP  = 4'd0;
    localparam opcodeT OP_ADD  = 4'd1;
    localparam opcodeT OP_SUB  = 4'd2;
    localparam opcodeT OP_AND  = 4'd3;
    localparam opcodeT OP_OR   = 4'd4;
    localparam opcodeT OP_XOR  = 4'd5;
    localparam opcodeT OP_SLL  = 4'd6;
    localparam opcodeT OP_SRL  = 4'd7;
    localparam opcodeT OP_ADDI = 4'd8;
    localparam opcodeT OP_LUI  = 4'd9;

    // Instruction layout.
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 28;
    localparam int RC_MSB     = 27;
    localparam int RC_LSB     = 24;
    localparam int RA_MSB     = 23;
    localparam int RA_LSB     = 20;
    localparam int RB_MSB     = 19;
    localparam int RB_LSB     = 16;
    localparam int IMM_MSB    = 15;
    localparam int IMM_LSB    = 0;

endpackage

`default_nettype wire
